/* flist.f */
design/bbc_video_pkg.sv
design/video_char_if.sv
design/crtc_core.sv
design/video_fetch.sv
design/char_fifo.sv
design/pixel_serializer.sv
design/bbc_video_top.sv
verification/tb_bbc_video.sv

/* Bender.yml */
package:
  name: bbc_video

sources:
  - design/bbc_video_pkg.sv
  - design/video_char_if.sv
  - design/crtc_core.sv
  - design/video_fetch.sv
  - design/char_fifo.sv
  - design/pixel_serializer.sv
  - design/bbc_video_top.sv
  - target: test
    files:
      - verification/tb_bbc_video.sv

/* verification/tb_bbc_video.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_bbc_video;
	import bbc_video_pkg::*;

	// Run length of each test group in clock cycles
	localparam int SYNC_CYC  = 200 * 4;
	localparam int ADDR_CYC  = 5 * 128 * 4;
	localparam int PIX_CYC   = 320 * (4 + 8 + 16);
	localparam int OVF_CYC   = 400 + 320;
	localparam int SETUP_CYC = 12 * 80;
	localparam int TIMEOUT   = 2 * (SYNC_CYC + ADDR_CYC + PIX_CYC + OVF_CYC + SETUP_CYC);

	logic              clk;
	logic              rst_n;
	logic              crtc_clken;
	logic              pix_clken;
	logic              cpu_clken;
	logic              crtc_enable;
	logic              vidproc_enable;
	logic              cpu_r_nw;
	logic              cpu_rs;
	logic [7:0]        cpu_di;
	wire  [7:0]        crtc_do;
	logic              latch_we;
	logic [2:0]        latch_adr;
	logic              latch_bit;
	wire  [VADR_W-1:0] vid_adr;
	wire  [7:0]        vid_di;
	wire               hsync;
	wire               vsync;
	wire               video_r;
	wire               video_g;
	wire               video_b;
	wire               overflow;

	logic [7:0]  vram [1 << VADR_W];
	int          errors;
	int          cycles;
	logic        clk_run;
	int          crtc_per;
	int          pix_per;
	int          crtc_cnt;
	int          pix_cnt;

	// Programmed frame and the testbench's own CRTC count
	logic [7:0]  c_r0;
	logic [7:0]  c_r1;
	logic [7:0]  c_r4;
	logic [7:0]  c_r6;
	logic [7:0]  c_r9;
	logic [7:0]  c_r3;
	logic [13:0] c_start;
	logic [1:0]  tb_offs;
	int          m_h;
	int          m_line;
	int          m_row;
	logic [13:0] m_marow;
	rgb_t        pal [16];

	bbc_video_top #(.FIFO_DEPTH(4)) u_dut (
		.CLK32M_I(clk), .rst_n(rst_n), .crtc_clken(crtc_clken), .pix_clken(pix_clken),
		.cpu_clken(cpu_clken), .crtc_enable(crtc_enable), .vidproc_enable(vidproc_enable),
		.cpu_r_nw(cpu_r_nw), .cpu_rs(cpu_rs), .cpu_di(cpu_di), .crtc_do(crtc_do),
		.latch_we(latch_we), .latch_adr(latch_adr), .latch_bit(latch_bit),
		.vid_adr(vid_adr), .vid_di(vid_di), .hsync(hsync), .vsync(vsync),
		.video_r(video_r), .video_g(video_g), .video_b(video_b), .overflow(overflow)
	);

	// Video RAM answers from the registered address
	assign vid_di = vram[vid_adr];

	always #5 clk = ~clk;

	// Clock enable strobes from free running counters
	always @(posedge clk)
	begin
		#1;
		if (!clk_run)
		begin
			crtc_clken = 1'b0;
			pix_clken  = 1'b0;
			crtc_cnt   = 0;
			pix_cnt    = 0;
		end
		else
		begin
			crtc_clken = (crtc_cnt == 0);
			pix_clken  = (pix_cnt == 0);
			crtc_cnt   = (crtc_cnt + 1 == crtc_per) ? 0 : crtc_cnt + 1;
			pix_cnt    = (pix_cnt + 1 == pix_per) ? 0 : pix_cnt + 1;
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT)
		begin
			$display("Timeout: simulation ran past %0d cycles", TIMEOUT);
			$display("TEST FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// Display address rule with the screen wrap correction
	function automatic logic [VADR_W-1:0] exp_vid_adr(input logic [13:0] m,
		input logic [4:0] r, input logic [1:0] offs);
		logic [3:0] nib;
		nib = m[11:8];
		if (m[12])
			nib = nib + ((offs == 2'd0) ? 4'd8 : (offs == 2'd1) ? 4'd12 :
				(offs == 2'd2) ? 4'd6 : 4'd11);
		if (m[13])
			return {nib[3], 4'b1111, m[9:0]};
		return {nib, m[7:0], r[2:0]};
	endfunction

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_adr(input string name, input logic [VADR_W-1:0] got,
		input logic [VADR_W-1:0] exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic do_reset;
		clk_run = 1'b0;
		@(posedge clk);
		#1 rst_n = 1'b0;
		repeat (10) @(posedge clk);
		#1 rst_n = 1'b1;
		@(posedge clk);
		#1;
	endtask

	task automatic cpu_write(input logic to_crtc, input logic rs, input logic [7:0] d);
		@(posedge clk);
		#1;
		cpu_clken      = 1'b1;
		crtc_enable    = to_crtc;
		vidproc_enable = !to_crtc;
		cpu_r_nw       = 1'b0;
		cpu_rs         = rs;
		cpu_di         = d;
		@(posedge clk);
		#1;
		cpu_clken      = 1'b0;
		crtc_enable    = 1'b0;
		vidproc_enable = 1'b0;
		cpu_r_nw       = 1'b1;
	endtask

	task automatic crtc_write(input logic [3:0] idx, input logic [7:0] val);
		cpu_write(1'b1, 1'b0, {4'd0, idx});
		cpu_write(1'b1, 1'b1, val);
	endtask

	task automatic latch_write(input logic [2:0] adr, input logic b);
		@(posedge clk);
		#1;
		latch_we  = 1'b1;
		latch_adr = adr;
		latch_bit = b;
		@(posedge clk);
		#1 latch_we = 1'b0;
	endtask

	task automatic set_frame(input logic [7:0] r0, input logic [7:0] r1, input logic [7:0] r3,
		input logic [7:0] r9, input logic [7:0] hi, input logic [7:0] lo);
		c_r0 = r0;
		c_r1 = r1;
		c_r3 = r3;
		c_r4 = 8'd3;
		c_r6 = 8'd2;
		c_r9 = r9;
		c_start = {hi[5:0], lo};
		crtc_write(4'd0, r0);
		crtc_write(4'd1, r1);
		crtc_write(4'd2, 8'd5);
		crtc_write(4'd3, r3);
		crtc_write(4'd4, c_r4);
		crtc_write(4'd6, c_r6);
		crtc_write(4'd7, 8'd2);
		crtc_write(4'd9, r9);
		crtc_write(4'd12, hi);
		crtc_write(4'd13, lo);
	endtask

	task automatic start_run(input int cp, input int pp);
		m_h     = 0;
		m_line  = 0;
		m_row   = 0;
		m_marow = '0;
		crtc_per = cp;
		pix_per  = pp;
		clk_run  = 1'b1;
	endtask

	// Character position of one strobe before the count steps
	task automatic model_step(output logic [13:0] m, output logic [4:0] r, output logic d);
		m = m_marow + 14'(m_h);
		r = 5'(m_line);
		d = (m_h < c_r1) && (m_row < c_r6);
		if (m_h >= c_r0)
		begin
			m_h = 0;
			if (m_line >= c_r9)
			begin
				m_line = 0;
				if (m_row >= c_r4)
				begin
					m_row   = 0;
					m_marow = c_start;
				end
				else
				begin
					m_row++;
					m_marow = m_marow + 14'(c_r1);
				end
			end
			else
				m_line++;
		end
		else
			m_h++;
	endtask

	task automatic wait_crtc;
		do
			@(posedge clk);
		while (!crtc_clken);
		#2;
	endtask

	task automatic wait_pix;
		do
			@(posedge clk);
		while (!pix_clken);
		#2;
	endtask

	task automatic reset_and_regs;
		do_reset;
		check_bit("hsync", hsync, 1'b0);
		check_bit("vsync", vsync, 1'b0);
		check_bit("video_r", video_r, 1'b0);
		check_bit("video_g", video_g, 1'b0);
		check_bit("video_b", video_b, 1'b0);
		check_bit("overflow", overflow, 1'b0);
		check_adr("vid_adr", vid_adr, '0);
		crtc_write(4'd12, 8'h13);
		crtc_write(4'd13, 8'h5a);
		crtc_write(4'd0, 8'h3f);
		cpu_write(1'b1, 1'b0, 8'd12);
		#1 cpu_rs = 1'b1;
		#1 check_byte("crtc_do R12", crtc_do, 8'h13);
		cpu_write(1'b1, 1'b0, 8'd13);
		#1 cpu_rs = 1'b1;
		#1 check_byte("crtc_do R13", crtc_do, 8'h5a);
		cpu_write(1'b1, 1'b0, 8'd0);
		#1 cpu_rs = 1'b1;
		#1 check_byte("crtc_do R0", crtc_do, 8'h00);
		cpu_rs = 1'b0;
	endtask

	task automatic sync_timing;
		int   k;
		int   h_last;
		int   v_last;
		int   h_w;
		int   v_rises;
		logic ph;
		logic pv;
		do_reset;
		set_frame(8'd7, 8'd4, 8'h22, 8'd1, 8'h00, 8'h00);
		start_run(4, 4);
		h_last  = -1;
		v_last  = -1;
		h_w     = 0;
		v_rises = 0;
		ph      = 1'b0;
		pv      = 1'b0;
		for (k = 0; k < 200; k++)
		begin
			wait_crtc;
			if (hsync)
				h_w++;
			if (hsync && !ph)
			begin
				if (h_last >= 0)
					check_byte("hsync period", 8'(k - h_last), c_r0 + 8'd1);
				h_last = k;
			end
			if (!hsync && ph)
			begin
				check_byte("hsync width", 8'(h_w), {4'd0, c_r3[3:0]});
				h_w = 0;
			end
			if (vsync && !pv)
			begin
				if (v_last >= 0)
					check_byte("vsync period", 8'(k - v_last),
						8'((c_r4 + 1) * (c_r9 + 1) * (c_r0 + 1)));
				v_last = k;
				v_rises++;
			end
			ph = hsync;
			pv = vsync;
		end
		if (v_rises < 2)
		begin
			$display("vsync did not rise twice during the sync test");
			errors++;
		end
	endtask

	task automatic addr_translation;
		int          cfg;
		int          k;
		logic [13:0] m;
		logic [4:0]  r;
		logic        d;
		for (cfg = 0; cfg < 5; cfg++)
		begin
			do_reset;
			if (cfg < 4)
				set_frame(8'd7, 8'd4, 8'h22, 8'd1, 8'h13, 8'h20);
			else
				set_frame(8'd7, 8'd4, 8'h22, 8'd1, 8'h28, 8'h10);
			tb_offs = (cfg < 4) ? 2'(cfg) : 2'd2;
			latch_write(3'd4, tb_offs[0]);
			latch_write(3'd5, tb_offs[1]);
			start_run(4, 4);
			for (k = 0; k < 128; k++)
			begin
				wait_crtc;
				model_step(m, r, d);
				@(posedge clk);
				#2 check_adr("vid_adr", vid_adr, exp_vid_adr(m, r, tb_offs));
			end
		end
	endtask

	task automatic pixel_output(input ppb_e mode);
		int          k;
		int          p;
		int          ppb_n;
		logic [13:0] m;
		logic [4:0]  r;
		logic        d;
		logic [7:0]  bits;
		rgb_t        got;
		rgb_t        exp_q [$];
		logic        started;
		ppb_n = (mode == PPB_8) ? 8 : (mode == PPB_4) ? 4 : 2;
		do_reset;
		set_frame(8'd7, 8'd4, 8'h22, 8'd9, 8'h00, 8'h00);
		cpu_write(1'b0, 1'b0, {6'd0, mode});
		// No palette entry is black, so the first lit pixel marks the start
		for (k = 0; k < 16; k++)
		begin
			pal[k] = rgb_t'(3'((k % 7) + 1));
			cpu_write(1'b0, 1'b1, {4'(k), 1'b0, 3'(pal[k])});
		end
		start_run(2 * ppb_n, 2);
		for (k = 0; k < 320; k++)
		begin
			model_step(m, r, d);
			bits = vram[exp_vid_adr(m, r, 2'd0)];
			for (p = 0; p < ppb_n; p++)
			begin
				exp_q.push_back((d && !r[3]) ? pal[{bits[7], bits[5], bits[3], bits[1]}] : '0);
				bits = {bits[6:0], 1'b1};
			end
		end
		started = 1'b0;
		while (exp_q.size() > 0)
		begin
			wait_pix;
			got = '{r: video_r, g: video_g, b: video_b};
			if (hsync || vsync)
				check_rgb("rgb in sync", got, '0);
			if (got != '0)
				started = 1'b1;
			if (started)
				check_rgb("rgb", got, exp_q.pop_front());
		end
	endtask

	task automatic overflow_sticky;
		int k;
		do_reset;
		set_frame(8'd7, 8'd4, 8'h22, 8'd1, 8'h00, 8'h00);
		start_run(2, 8);
		k = 0;
		while (!overflow && k < 400)
		begin
			@(posedge clk);
			#2 k++;
		end
		if (!overflow)
		begin
			$display("overflow never rose with the fast character clock");
			errors++;
		end
		// Character strobes stop and the FIFO drains to empty
		crtc_per = 1 << 20;
		repeat (320)
		begin
			@(posedge clk);
			#2 check_bit("overflow", overflow, 1'b1);
		end
		do_reset;
		check_bit("overflow", overflow, 1'b0);
	endtask

	initial
	begin
		logic [31:0] s;
		logic [7:0]  b;
		clk = 1'b0;
		rst_n = 1'b0;
		crtc_clken = 1'b0;
		pix_clken = 1'b0;
		cpu_clken = 1'b0;
		crtc_enable = 1'b0;
		vidproc_enable = 1'b0;
		cpu_r_nw = 1'b1;
		cpu_rs = 1'b0;
		cpu_di = 8'd0;
		latch_we = 1'b0;
		latch_adr = 3'd0;
		latch_bit = 1'b0;
		clk_run = 1'b0;
		crtc_per = 4;
		pix_per = 4;
		errors = 0;
		cycles = 0;
		s = 32'h94ae;
		for (int a = 0; a < (1 << VADR_W); a++)
		begin
			b = '0;
			for (int i = 0; i < 8; i++)
			begin
				s = lfsr_step(s);
				b = {b[6:0], s[0]};
			end
			vram[a] = b;
		end

		reset_and_regs;
		sync_timing;
		addr_translation;
		pixel_output(PPB_8);
		pixel_output(PPB_4);
		pixel_output(PPB_2);
		overflow_sticky;

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* design/bbc_video_top.sv */
`timescale 1ns/1ns
`default_nettype none

module bbc_video_top #(
	parameter int FIFO_DEPTH = bbc_video_pkg::FIFO_DEPTH_DEF
) (
	input  wire                               CLK32M_I,
	input  wire                               rst_n,
	input  wire                               crtc_clken,
	input  wire                               pix_clken,
	input  wire                               cpu_clken,
	input  wire                               crtc_enable,
	input  wire                               vidproc_enable,
	input  wire                               cpu_r_nw,
	input  wire                               cpu_rs,
	input  wire  [7:0]                        cpu_di,
	output wire  [7:0]                        crtc_do,
	input  wire                               latch_we,
	input  wire  [2:0]                        latch_adr,
	input  wire                               latch_bit,
	output wire  [bbc_video_pkg::VADR_W-1:0]  vid_adr,
	input  wire  [7:0]                        vid_di,
	output wire                               hsync,
	output wire                               vsync,
	output wire                               video_r,
	output wire                               video_g,
	output wire                               video_b,
	output wire                               overflow
);
	import bbc_video_pkg::*;

	wire [MA_W-1:0] crtc_ma;
	wire [RA_W-1:0] crtc_ra;
	wire            crtc_de;

	video_char_if u_chars ();

	crtc_core u_crtc (
		.CLK32M_I    (CLK32M_I),
		.rst_n       (rst_n),
		.crtc_clken  (crtc_clken),
		.cpu_clken   (cpu_clken),
		.crtc_enable (crtc_enable),
		.cpu_r_nw    (cpu_r_nw),
		.cpu_rs      (cpu_rs),
		.cpu_di      (cpu_di),
		.crtc_do     (crtc_do),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (crtc_de),
		.ma          (crtc_ma),
		.ra          (crtc_ra)
	);

	video_fetch u_fetch (
		.CLK32M_I   (CLK32M_I),
		.rst_n      (rst_n),
		.crtc_clken (crtc_clken),
		.ma         (crtc_ma),
		.ra         (crtc_ra),
		.de         (crtc_de),
		.latch_we   (latch_we),
		.latch_adr  (latch_adr),
		.latch_bit  (latch_bit),
		.vid_adr    (vid_adr),
		.vid_di     (vid_di),
		.chars      (u_chars.producer)
	);

	char_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.CLK32M_I (CLK32M_I),
		.rst_n    (rst_n),
		.chars    (u_chars.buffer),
		.overflow (overflow)
	);

	pixel_serializer u_ula (
		.CLK32M_I       (CLK32M_I),
		.rst_n          (rst_n),
		.pix_clken      (pix_clken),
		.cpu_clken      (cpu_clken),
		.vidproc_enable (vidproc_enable),
		.cpu_r_nw       (cpu_r_nw),
		.cpu_rs         (cpu_rs),
		.cpu_di         (cpu_di),
		.chars          (u_chars.consumer),
		.video_r        (video_r),
		.video_g        (video_g),
		.video_b        (video_b)
	);

endmodule

`default_nettype wire

/* design/pixel_serializer.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_serializer (
	input  wire            CLK32M_I,
	input  wire            rst_n,
	input  wire            pix_clken,
	input  wire            cpu_clken,
	input  wire            vidproc_enable,
	input  wire            cpu_r_nw,
	input  wire            cpu_rs,
	input  wire  [7:0]     cpu_di,
	video_char_if.consumer chars,
	output logic           video_r,
	output logic           video_g,
	output logic           video_b
);
	import bbc_video_pkg::*;

	ppb_e       ctrl_ppb;
	rgb_t       palette [16];
	logic [7:0] shift_reg;
	logic [3:0] pix_left;
	logic       byte_disen;
	logic [3:0] byte_pixels;
	logic       byte_done;
	logic       load;
	logic [7:0] cur_bits;
	logic [3:0] logical;
	rgb_t       pix_rgb;

	// Control register and palette writes
	always_ff @(posedge CLK32M_I or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ctrl_ppb <= PPB_8;
			palette  <= '{default: '0};
		end
		else if (cpu_clken && vidproc_enable && !cpu_r_nw)
		begin
			if (!cpu_rs)
				ctrl_ppb <= ppb_e'(cpu_di[1:0]);
			else
				palette[cpu_di[7:4]] <= rgb_t'(cpu_di[2:0]);
		end
	end

	always_comb
	begin
		case (ctrl_ppb)
			PPB_8:   byte_pixels = 4'd8;
			PPB_4:   byte_pixels = 4'd4;
			default: byte_pixels = 4'd2;
		endcase
	end

	assign byte_done = (pix_left == 4'd0);
	assign load      = byte_done && !chars.empty;
	assign chars.pop = pix_clken && load;

	// First pixel of a new byte comes straight from the FIFO head
	assign cur_bits = load ? chars.pop_item.data : shift_reg;
	assign logical  = {cur_bits[7], cur_bits[5], cur_bits[3], cur_bits[1]};

	always_ff @(posedge CLK32M_I or negedge rst_n)
	begin
		if (!rst_n)
		begin
			shift_reg  <= '0;
			pix_left   <= '0;
			byte_disen <= 1'b0;
			pix_rgb    <= '0;
		end
		else if (pix_clken)
		begin
			if (load)
			begin
				shift_reg  <= {cur_bits[6:0], 1'b1};
				pix_left   <= byte_pixels - 4'd1;
				byte_disen <= chars.pop_item.disen;
				pix_rgb    <= chars.pop_item.disen ? palette[logical] : '0;
			end
			else if (!byte_done)
			begin
				shift_reg <= {shift_reg[6:0], 1'b1};
				pix_left  <= pix_left - 4'd1;
				pix_rgb   <= byte_disen ? palette[logical] : '0;
			end
			else
				// Nothing left to show
				pix_rgb <= '0;
		end
	end

	assign video_r = pix_rgb.r;
	assign video_g = pix_rgb.g;
	assign video_b = pix_rgb.b;

endmodule

`default_nettype wire

/* design/char_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module char_fifo #(
	parameter int FIFO_DEPTH = bbc_video_pkg::FIFO_DEPTH_DEF
) (
	input  wire          CLK32M_I,
	input  wire          rst_n,
	video_char_if.buffer chars,
	output logic         overflow
);
	import bbc_video_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	char_item_t       mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign chars.full     = (count == CNT_W'(FIFO_DEPTH));
	assign chars.empty    = (count == '0);
	assign chars.pop_item = mem[rd_ptr];

	assign do_push = chars.push && !chars.full;
	assign do_pop  = chars.pop && !chars.empty;

	always_ff @(posedge CLK32M_I)
	begin
		if (do_push)
			mem[wr_ptr] <= chars.push_item;
	end

	always_ff @(posedge CLK32M_I or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Sticky until reset
			if (chars.push && chars.full)
				overflow <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* design/video_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module video_fetch (
	input  wire                                CLK32M_I,
	input  wire                                rst_n,
	input  wire                                crtc_clken,
	input  wire  [bbc_video_pkg::MA_W-1:0]     ma,
	input  wire  [bbc_video_pkg::RA_W-1:0]     ra,
	input  wire                                de,
	input  wire                                latch_we,
	input  wire  [2:0]                         latch_adr,
	input  wire                                latch_bit,
	output logic [bbc_video_pkg::VADR_W-1:0]   vid_adr,
	input  wire  [7:0]                         vid_di,
	video_char_if.producer                     chars
);
	import bbc_video_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_CAPT
	} fetch_state_e;

	fetch_state_e      state;
	logic [1:0]        disp_addr_offs;
	logic [3:0]        aa;
	logic [VADR_W-1:0] adr_next;
	logic              disen_q;

	// Latch bits 4 and 5 select the screen wrap offset
	always_ff @(posedge CLK32M_I or negedge rst_n)
	begin
		if (!rst_n)
			disp_addr_offs <= 2'b00;
		else if (latch_we)
		begin
			if (latch_adr == 3'd4)
				disp_addr_offs[0] <= latch_bit;
			else if (latch_adr == 3'd5)
				disp_addr_offs[1] <= latch_bit;
		end
	end

	// Wrap correction for the 0x8000 boundary
	always_comb
	begin
		aa = ma[11:8];
		if (ma[12])
		begin
			case (disp_addr_offs)
				2'd0:    aa = ma[11:8] + 4'd8;
				2'd1:    aa = ma[11:8] + 4'd12;
				2'd2:    aa = ma[11:8] + 4'd6;
				default: aa = ma[11:8] + 4'd11;
			endcase
		end
		if (ma[13])
			adr_next = {aa[3], 4'b1111, ma[9:0]};
		else
			adr_next = {aa, ma[7:0], ra[2:0]};
	end

	always_ff @(posedge CLK32M_I or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= ST_IDLE;
			vid_adr <= '0;
			disen_q <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (crtc_clken)
						state <= ST_ADDR;
				end
				ST_ADDR:
				begin
					// CRTC outputs are settled one cycle after the strobe
					vid_adr <= adr_next;
					disen_q <= de && !ra[3];
					state   <= ST_CAPT;
				end
				default:
				begin
					state <= crtc_clken ? ST_ADDR : ST_IDLE;
				end
			endcase
		end
	end

	// RAM byte is pushed in the capture cycle
	assign chars.push      = (state == ST_CAPT);
	assign chars.push_item = '{data: vid_di, disen: disen_q};

endmodule

`default_nettype wire

/* design/crtc_core.sv */
`timescale 1ns/1ns
`default_nettype none

module crtc_core (
	input  wire                              CLK32M_I,
	input  wire                              rst_n,
	input  wire                              crtc_clken,
	input  wire                              cpu_clken,
	input  wire                              crtc_enable,
	input  wire                              cpu_r_nw,
	input  wire                              cpu_rs,
	input  wire  [7:0]                       cpu_di,
	output logic [7:0]                       crtc_do,
	output logic                             hsync,
	output logic                             vsync,
	output logic                             de,
	output logic [bbc_video_pkg::MA_W-1:0]   ma,
	output logic [bbc_video_pkg::RA_W-1:0]   ra
);
	import bbc_video_pkg::*;

	crtc_reg_e addr_reg;

	// Register file
	logic [7:0]      r0_htotal;
	logic [7:0]      r1_hdisp;
	logic [7:0]      r2_hsync_pos;
	logic [7:0]      r3_sync_width;
	logic [6:0]      r4_vtotal;
	logic [6:0]      r6_vdisp;
	logic [6:0]      r7_vsync_pos;
	logic [4:0]      r9_max_scan;
	logic [5:0]      r12_start_hi;
	logic [7:0]      r13_start_lo;

	// Timing counters
	logic [7:0]      h_cnt;
	logic [4:0]      line_cnt;
	logic [6:0]      row_cnt;
	logic [MA_W-1:0] ma_row;
	logic [3:0]      vs_cnt;
	logic [8:0]      hs_end;
	logic            hs_win;

	always_ff @(posedge CLK32M_I or negedge rst_n)
	begin
		if (!rst_n)
		begin
			addr_reg      <= R0;
			r0_htotal     <= '0;
			r1_hdisp      <= '0;
			r2_hsync_pos  <= '0;
			r3_sync_width <= '0;
			r4_vtotal     <= '0;
			r6_vdisp      <= '0;
			r7_vsync_pos  <= '0;
			r9_max_scan   <= '0;
			r12_start_hi  <= '0;
			r13_start_lo  <= '0;
		end
		else if (cpu_clken && crtc_enable && !cpu_r_nw)
		begin
			if (!cpu_rs)
				addr_reg <= crtc_reg_e'(cpu_di[3:0]);
			else
			begin
				case (addr_reg)
					R0:      r0_htotal     <= cpu_di;
					R1:      r1_hdisp      <= cpu_di;
					R2:      r2_hsync_pos  <= cpu_di;
					R3:      r3_sync_width <= cpu_di;
					R4:      r4_vtotal     <= cpu_di[6:0];
					R6:      r6_vdisp      <= cpu_di[6:0];
					R7:      r7_vsync_pos  <= cpu_di[6:0];
					R9:      r9_max_scan   <= cpu_di[4:0];
					R12:     r12_start_hi  <= cpu_di[5:0];
					R13:     r13_start_lo  <= cpu_di;
					default: ;
				endcase
			end
		end
	end

	// Only the start address reads back
	always_comb
	begin
		crtc_do = 8'd0;
		if (cpu_rs)
		begin
			case (addr_reg)
				R12:     crtc_do = {2'b00, r12_start_hi};
				R13:     crtc_do = r13_start_lo;
				default: crtc_do = 8'd0;
			endcase
		end
	end

	assign hs_end = {1'b0, r2_hsync_pos} + {5'd0, r3_sync_width[3:0]};
	assign hs_win = (h_cnt >= r2_hsync_pos) && ({1'b0, h_cnt} < hs_end);

	always_ff @(posedge CLK32M_I or negedge rst_n)
	begin
		if (!rst_n)
		begin
			h_cnt    <= '0;
			line_cnt <= '0;
			row_cnt  <= '0;
			ma_row   <= '0;
			vs_cnt   <= '0;
			hsync    <= 1'b0;
			vsync    <= 1'b0;
			de       <= 1'b0;
			ma       <= '0;
			ra       <= '0;
		end
		else if (crtc_clken)
		begin
			// Outputs follow the count of this strobe
			ma    <= ma_row + MA_W'(h_cnt);
			ra    <= line_cnt;
			de    <= (h_cnt < r1_hdisp) && (row_cnt < r6_vdisp);
			hsync <= hs_win;

			if (h_cnt >= r0_htotal)
			begin
				h_cnt <= '0;
				if (line_cnt >= r9_max_scan)
				begin
					line_cnt <= '0;
					if (row_cnt >= r4_vtotal)
					begin
						// New frame restarts at the programmed address
						row_cnt <= '0;
						ma_row  <= {r12_start_hi, r13_start_lo};
					end
					else
					begin
						row_cnt <= row_cnt + 7'd1;
						ma_row  <= ma_row + MA_W'(r1_hdisp);
					end
				end
				else
					line_cnt <= line_cnt + 5'd1;
			end
			else
				h_cnt <= h_cnt + 8'd1;

			// Vsync width counted in lines at each line start
			if (h_cnt == 8'd0)
			begin
				if (row_cnt == r7_vsync_pos && line_cnt == 5'd0
					&& r3_sync_width[7:4] != 4'd0)
				begin
					vsync  <= 1'b1;
					vs_cnt <= r3_sync_width[7:4] - 4'd1;
				end
				else if (vs_cnt != 4'd0)
					vs_cnt <= vs_cnt - 4'd1;
				else
					vsync <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* design/video_char_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Character bytes from the fetch block through the FIFO to the ULA
interface video_char_if;
	import bbc_video_pkg::*;

	logic       push;
	char_item_t push_item;
	logic       full;
	logic       pop;
	char_item_t pop_item;
	logic       empty;

	modport producer (output push, output push_item, input full);

	modport buffer (input push, input push_item, input pop,
		output full, output pop_item, output empty);

	modport consumer (output pop, input pop_item, input empty);

endinterface

`default_nettype wire

/* design/bbc_video_pkg.sv */
`default_nettype none

package bbc_video_pkg;

	// Address widths of the display path
	localparam int MA_W   = 14;
	localparam int RA_W   = 5;
	localparam int VADR_W = 15;

	// Character FIFO depth used unless the top level overrides it
	localparam int FIFO_DEPTH_DEF = 4;

	// CRTC registers that are implemented
	typedef enum logic [3:0] {
		R0  = 4'd0,
		R1  = 4'd1,
		R2  = 4'd2,
		R3  = 4'd3,
		R4  = 4'd4,
		R6  = 4'd6,
		R7  = 4'd7,
		R9  = 4'd9,
		R12 = 4'd12,
		R13 = 4'd13
	} crtc_reg_e;

	// Pixels per byte from the ULA control register
	typedef enum logic [1:0] {
		PPB_8 = 2'd0,
		PPB_4 = 2'd1,
		PPB_2 = 2'd2
	} ppb_e;

	typedef struct packed {
		logic [7:0] data;
		logic       disen;
	} char_item_t;

	typedef struct packed {
		logic r;
		logic g;
		logic b;
	} rgb_t;

endpackage

`default_nettype wire
